/* alu_cmp.sv */
`timescale 1ns/100ps

module alu_cmp (
    input  rv32i_pkg::alu_ops aluop,
    input  rv32i_pkg::rv32i_word a,
    input  rv32i_pkg::rv32i_word b,
    input  rv32i_pkg::rv32i_word cmp_a,
    input  rv32i_pkg::rv32i_word cmp_b,
    input  rv32i_pkg::branch_funct3_t cmpop,
    output rv32i_pkg::rv32i_word f,
    output logic br_en
);

    always_comb
    begin
        case (aluop)
            rv32i_pkg::alu_sll:  f = a << b[4:0];
            rv32i_pkg::alu_xor:  f = a ^ b;
            rv32i_pkg::alu_srl:  f = a >> b[4:0];
            rv32i_pkg::alu_or:   f = a | b;
            rv32i_pkg::alu_and:  f = a & b;
            rv32i_pkg::alu_sub:  f = a - b;
            rv32i_pkg::alu_sra:  f = $unsigned($signed(a) >>> b[4:0]);   // sign fill
            default:             f = a + b;
        endcase
    end

    always_comb
    begin
        case (cmpop)
            rv32i_pkg::bne:  br_en = (cmp_a != cmp_b);
            rv32i_pkg::blt:  br_en = ($signed(cmp_a) < $signed(cmp_b));
            rv32i_pkg::bge:  br_en = ($signed(cmp_a) >= $signed(cmp_b));
            rv32i_pkg::bltu: br_en = (cmp_a < cmp_b);
            rv32i_pkg::bgeu: br_en = (cmp_a >= cmp_b);
            default:         br_en = (cmp_a == cmp_b);            // beq
        endcase
    end

endmodule

/* compile.f */
rv32i_pkg.sv
cpu_ctrl_if.sv
regfile.sv
alu_cmp.sv
cpu_control.sv
cpu_datapath.sv
mp_cpu.sv
tb_mem_model.sv
tb_mp_cpu_asserts.sv
tb_mp_cpu.sv

/* cpu_control.sv */
`timescale 1ns/100ps

module cpu_control (
    input  logic clk,
    input  logic reset,
    cpu_ctrl_if.control ctrl,
    input  logic mem_resp,
    output logic mem_read,
    output logic mem_write,
    output rv32i_pkg::rv32i_mem_wmask mem_byte_enable
);

    typedef enum logic [4:0] {
        fetch1, fetch2, fetch3, decode,
        s_auipc, s_lui, s_jal, s_jalr, s_br,
        s_imm, s_sra, s_slt, s_sltu,
        s_reg, s_reg_sra, s_reg_slt, s_reg_sltu,
        s_ld_calc, s_ldr1, s_ldr2,
        s_st_calc, s_str1, s_str2
    } state_t;

    state_t state;
    state_t next_state;
    rv32i_pkg::arith_funct3_t arith_op;
    rv32i_pkg::store_funct3_t store_op;

    assign arith_op = rv32i_pkg::arith_funct3_t'(ctrl.funct3);
    assign store_op = rv32i_pkg::store_funct3_t'(ctrl.funct3);

    always_comb
    begin : state_actions
        ctrl.load_pc = 1'b0;
        ctrl.load_ir = 1'b0;
        ctrl.load_regfile = 1'b0;
        ctrl.load_mar = 1'b0;
        ctrl.load_mdr = 1'b0;
        ctrl.load_mem_data_out = 1'b0;
        ctrl.pcmux_sel = 1'b0;
        ctrl.marmux_sel = 1'b0;
        ctrl.alumux1_sel = 1'b0;
        ctrl.cmpmux_sel = 1'b0;
        ctrl.alumux2_sel = 3'd0;
        ctrl.regfilemux_sel = 3'd0;
        ctrl.aluop = rv32i_pkg::alu_ops'({1'b0, ctrl.funct3});     // funct3 by default
        ctrl.cmpop = rv32i_pkg::branch_funct3_t'(ctrl.funct3);
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_byte_enable = 4'b1111;
        case (state)
            fetch1:      ctrl.load_mar = 1'b1;                   // mar <= pc
            fetch2:
            begin
                mem_read = 1'b1;                                  // hold until resp
                ctrl.load_mdr = mem_resp;
            end
            fetch3:      ctrl.load_ir = 1'b1;
            s_auipc:
            begin
                ctrl.alumux1_sel = 1'b1;                          // pc + u imm
                ctrl.alumux2_sel = 3'd1;
                ctrl.aluop = rv32i_pkg::alu_add;
                ctrl.load_regfile = 1'b1;
                ctrl.load_pc = 1'b1;
            end
            s_lui:
            begin
                ctrl.regfilemux_sel = 3'd2;                       // rd <= u imm
                ctrl.load_regfile = 1'b1;
                ctrl.load_pc = 1'b1;
            end
            s_jal, s_jalr:
            begin
                ctrl.alumux1_sel = (state == s_jal);              // pc or rs1 base
                ctrl.alumux2_sel = (state == s_jal) ? 3'd4 : 3'd0;
                ctrl.aluop = rv32i_pkg::alu_add;
                ctrl.pcmux_sel = 1'b1;
                ctrl.load_pc = 1'b1;
                ctrl.regfilemux_sel = 3'd4;                       // link pc+4
                ctrl.load_regfile = 1'b1;
            end
            s_br:
            begin
                ctrl.alumux1_sel = 1'b1;                          // target pc + b imm
                ctrl.alumux2_sel = 3'd2;
                ctrl.aluop = rv32i_pkg::alu_add;
                ctrl.pcmux_sel = ctrl.br_en;                      // taken picks target
                ctrl.load_pc = 1'b1;
            end
            s_imm, s_sra, s_reg, s_reg_sra:
            begin
                ctrl.load_regfile = 1'b1;
                ctrl.load_pc = 1'b1;
                if (state == s_reg || state == s_reg_sra)
                    ctrl.alumux2_sel = 3'd5;                      // rs2 operand
                if (state == s_sra || state == s_reg_sra)
                    ctrl.aluop = rv32i_pkg::alu_sra;
                if (state == s_reg && ctrl.funct7[5] && arith_op == rv32i_pkg::add)
                    ctrl.aluop = rv32i_pkg::alu_sub;              // sub shares funct3 with add
            end
            s_slt, s_sltu, s_reg_slt, s_reg_sltu:
            begin
                ctrl.cmpop = (state == s_slt || state == s_reg_slt) ?
                             rv32i_pkg::blt : rv32i_pkg::bltu;
                ctrl.cmpmux_sel = (state == s_slt || state == s_sltu);   // imm compare
                ctrl.regfilemux_sel = 3'd1;                       // rd <= br_en
                ctrl.load_regfile = 1'b1;
                ctrl.load_pc = 1'b1;
            end
            s_ld_calc, s_st_calc:
            begin
                ctrl.alumux2_sel = (state == s_st_calc) ? 3'd3 : 3'd0;
                ctrl.aluop = rv32i_pkg::alu_add;
                ctrl.marmux_sel = 1'b1;                           // mar <= rs1 + imm
                ctrl.load_mar = 1'b1;
                ctrl.load_mem_data_out = (state == s_st_calc);    // capture rs2
            end
            s_ldr1:
            begin
                mem_read = 1'b1;
                ctrl.load_mdr = mem_resp;
            end
            s_ldr2:
            begin
                ctrl.regfilemux_sel = 3'd3;                       // rd <= mdr
                ctrl.load_regfile = 1'b1;
                ctrl.load_pc = 1'b1;
            end
            s_str1:
            begin
                mem_write = 1'b1;
                case (store_op)
                    rv32i_pkg::sb: mem_byte_enable = 4'b0001;
                    rv32i_pkg::sh: mem_byte_enable = 4'b0011;
                    default:       mem_byte_enable = 4'b1111;
                endcase
            end
            s_str2:      ctrl.load_pc = 1'b1;
            default:     ;                                        // decode waits
        endcase
    end

    always_comb
    begin : next_state_logic
        next_state = state;
        case (state)
            fetch1:      next_state = fetch2;
            fetch2:      if (mem_resp) next_state = fetch3;
            fetch3:      next_state = decode;
            decode:
            begin
                case (ctrl.opcode)
                    rv32i_pkg::op_lui:   next_state = s_lui;
                    rv32i_pkg::op_auipc: next_state = s_auipc;
                    rv32i_pkg::op_jal:   next_state = s_jal;
                    rv32i_pkg::op_jalr:  next_state = s_jalr;
                    rv32i_pkg::op_br:    next_state = s_br;
                    rv32i_pkg::op_load:  next_state = s_ld_calc;
                    rv32i_pkg::op_store: next_state = s_st_calc;
                    rv32i_pkg::op_imm, rv32i_pkg::op_reg:
                    begin
                        if (arith_op == rv32i_pkg::sr && ctrl.funct7[5])
                            next_state = (ctrl.opcode == rv32i_pkg::op_imm) ? s_sra : s_reg_sra;
                        else if (arith_op == rv32i_pkg::slt)
                            next_state = (ctrl.opcode == rv32i_pkg::op_imm) ? s_slt : s_reg_slt;
                        else if (arith_op == rv32i_pkg::sltu)
                            next_state = (ctrl.opcode == rv32i_pkg::op_imm) ? s_sltu : s_reg_sltu;
                        else
                            next_state = (ctrl.opcode == rv32i_pkg::op_imm) ? s_imm : s_reg;
                    end
                    default:             next_state = decode;     // unknown opcode hangs
                endcase
            end
            s_ld_calc:   next_state = s_ldr1;
            s_ldr1:      if (mem_resp) next_state = s_ldr2;
            s_st_calc:   next_state = s_str1;
            s_str1:      if (mem_resp) next_state = s_str2;
            default:     next_state = fetch1;                     // all execute states
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= fetch1;
        else
            state <= next_state;
    end

endmodule

/* cpu_ctrl_if.sv */
`timescale 1ns/100ps

interface cpu_ctrl_if;
    rv32i_pkg::rv32i_opcode opcode;           // decode fields from the ir
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic br_en;                              // comparator result
    logic load_pc;                            // register load strobes
    logic load_ir;
    logic load_regfile;
    logic load_mar;
    logic load_mdr;
    logic load_mem_data_out;
    logic pcmux_sel;                          // 0 pc+4, 1 alu target
    logic marmux_sel;                         // 0 pc, 1 alu address
    logic alumux1_sel;                        // 0 rs1, 1 pc
    logic cmpmux_sel;                         // 0 rs2, 1 i immediate
    logic [2:0] alumux2_sel;                  // i, u, b, s, j imm or rs2
    logic [2:0] regfilemux_sel;               // alu, cmp, u imm, mdr, pc+4
    rv32i_pkg::alu_ops aluop;
    rv32i_pkg::branch_funct3_t cmpop;

    modport control (
        input  opcode, funct3, funct7, br_en,
        output load_pc, load_ir, load_regfile, load_mar, load_mdr, load_mem_data_out,
        output pcmux_sel, marmux_sel, alumux1_sel, cmpmux_sel, alumux2_sel,
        output regfilemux_sel, aluop, cmpop
    );

    modport datapath (
        output opcode, funct3, funct7, br_en,
        input  load_pc, load_ir, load_regfile, load_mar, load_mdr, load_mem_data_out,
        input  pcmux_sel, marmux_sel, alumux1_sel, cmpmux_sel, alumux2_sel,
        input  regfilemux_sel, aluop, cmpop
    );
endinterface

/* cpu_datapath.sv */
`timescale 1ns/100ps

module cpu_datapath #(
    parameter rv32i_pkg::rv32i_word reset_pc = 32'h0000_0000
) (
    input  logic clk,
    input  logic reset,
    cpu_ctrl_if.datapath ctrl,
    input  rv32i_pkg::rv32i_word mem_rdata,
    output rv32i_pkg::rv32i_word mem_address,
    output rv32i_pkg::rv32i_word mem_wdata
);

    rv32i_pkg::rv32i_word pc;
    rv32i_pkg::rv32i_instr_u ir;
    rv32i_pkg::rv32i_word mar;
    rv32i_pkg::rv32i_word mdr;
    rv32i_pkg::rv32i_word mem_data_out;
    rv32i_pkg::rv32i_word i_imm;
    rv32i_pkg::rv32i_word s_imm;
    rv32i_pkg::rv32i_word b_imm;
    rv32i_pkg::rv32i_word u_imm;
    rv32i_pkg::rv32i_word j_imm;
    rv32i_pkg::rv32i_word rs1_out;
    rv32i_pkg::rv32i_word rs2_out;
    rv32i_pkg::rv32i_word alu_a;
    rv32i_pkg::rv32i_word alu_b;
    rv32i_pkg::rv32i_word cmp_b;
    rv32i_pkg::rv32i_word alu_out;
    rv32i_pkg::rv32i_word pc_plus4;
    rv32i_pkg::rv32i_word rf_in;
    logic br_en;

    // immediates, b and j are rebuilt from the s and u views
    assign i_imm = {{20{ir.i.imm12[11]}}, ir.i.imm12};
    assign s_imm = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
    assign b_imm = {{19{ir.s.imm_hi[6]}}, ir.s.imm_hi[6], ir.s.imm_lo[0],
                    ir.s.imm_hi[5:0], ir.s.imm_lo[4:1], 1'b0};
    assign u_imm = {ir.u.imm20, 12'h000};
    assign j_imm = {{11{ir.u.imm20[19]}}, ir.u.imm20[19], ir.u.imm20[7:0],
                    ir.u.imm20[8], ir.u.imm20[18:9], 1'b0};

    assign ctrl.opcode = rv32i_pkg::rv32i_opcode'(ir.r.opcode);
    assign ctrl.funct3 = ir.r.funct3;
    assign ctrl.funct7 = ir.r.funct7;
    assign ctrl.br_en = br_en;

    assign pc_plus4 = pc + 32'd4;
    assign alu_a = ctrl.alumux1_sel ? pc : rs1_out;
    assign cmp_b = ctrl.cmpmux_sel ? i_imm : rs2_out;

    always_comb
    begin
        case (ctrl.alumux2_sel)
            3'd1:    alu_b = u_imm;
            3'd2:    alu_b = b_imm;
            3'd3:    alu_b = s_imm;
            3'd4:    alu_b = j_imm;
            3'd5:    alu_b = rs2_out;
            default: alu_b = i_imm;
        endcase
        case (ctrl.regfilemux_sel)
            3'd1:    rf_in = {31'd0, br_en};                      // slt result
            3'd2:    rf_in = u_imm;
            3'd3:    rf_in = mdr;
            3'd4:    rf_in = pc_plus4;                            // link address
            default: rf_in = alu_out;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= reset_pc;
            ir <= '0;
            mar <= '0;
            mdr <= '0;
            mem_data_out <= '0;
        end
        else
        begin
            if (ctrl.load_pc)
                pc <= ctrl.pcmux_sel ? {alu_out[31:1], 1'b0} : pc_plus4;   // jalr clears bit 0
            if (ctrl.load_ir)
                ir <= mdr;
            if (ctrl.load_mar)
                mar <= ctrl.marmux_sel ? alu_out : pc;
            if (ctrl.load_mdr)
                mdr <= mem_rdata;
            if (ctrl.load_mem_data_out)
                mem_data_out <= rs2_out;                          // unshifted store data
        end
    end

    assign mem_address = mar;
    assign mem_wdata = mem_data_out;

    regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .load  (ctrl.load_regfile),
        .in    (rf_in),
        .src_a (ir.r.rs1),
        .src_b (ir.r.rs2),
        .dest  (ir.r.rd),
        .reg_a (rs1_out),
        .reg_b (rs2_out)
    );

    alu_cmp u_alu_cmp (
        .aluop (ctrl.aluop),
        .a     (alu_a),
        .b     (alu_b),
        .cmp_a (rs1_out),
        .cmp_b (cmp_b),
        .cmpop (ctrl.cmpop),
        .f     (alu_out),
        .br_en (br_en)
    );

endmodule

/* mp_cpu.sv */
`timescale 1ns/100ps

module mp_cpu #(
    parameter rv32i_pkg::rv32i_word reset_pc = 32'h0000_0000
) (
    input  logic clk,
    input  logic reset,
    input  logic mem_resp,
    input  rv32i_pkg::rv32i_word mem_rdata,
    output logic mem_read,
    output logic mem_write,
    output rv32i_pkg::rv32i_mem_wmask mem_byte_enable,
    output rv32i_pkg::rv32i_word mem_address,
    output rv32i_pkg::rv32i_word mem_wdata
);

    cpu_ctrl_if ctrl_if ();                                       // decode fields and strobes

    cpu_control u_control (
        .clk             (clk),
        .reset           (reset),
        .ctrl            (ctrl_if.control),
        .mem_resp        (mem_resp),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable)
    );

    cpu_datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl_if.datapath),
        .mem_rdata   (mem_rdata),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata)
    );

endmodule

/* regfile.sv */
`timescale 1ns/100ps

module regfile (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  rv32i_pkg::rv32i_word in,
    input  rv32i_pkg::rv32i_reg src_a,
    input  rv32i_pkg::rv32i_reg src_b,
    input  rv32i_pkg::rv32i_reg dest,
    output rv32i_pkg::rv32i_word reg_a,
    output rv32i_pkg::rv32i_word reg_b
);

    rv32i_pkg::rv32i_word data [32];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                data[i] <= '0;
        end
        else if (load && dest != 5'd0)                            // x0 stays zero
            data[dest] <= in;
    end

    assign reg_a = data[src_a];                                   // async reads
    assign reg_b = data[src_b];

endmodule

/* rv32i_pkg.sv */
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;          // data and address word
    typedef logic [4:0] rv32i_reg;            // register index
    typedef logic [3:0] rv32i_mem_wmask;      // byte lane enables

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,                // u type
        op_auipc = 7'b0010111,                // u type, pc relative
        op_jal   = 7'b1101111,                // j type
        op_jalr  = 7'b1100111,                // i type
        op_br    = 7'b1100011,                // b type
        op_load  = 7'b0000011,                // i type
        op_store = 7'b0100011,                // s type
        op_imm   = 7'b0010011,                // register-immediate arithmetic
        op_reg   = 7'b0110011,                // register-register arithmetic
        op_csr   = 7'b1110011                 // not executed, core hangs in decode
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq = 3'b000, bne = 3'b001, blt = 3'b100,
        bge = 3'b101, bltu = 3'b110, bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000, sh = 3'b001, sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add = 3'b000, sll = 3'b001, slt = 3'b010, sltu = 3'b011,
        axor = 3'b100, sr = 3'b101, aor = 3'b110, aand = 3'b111
    } arith_funct3_t;

    // low eight codes follow funct3, so funct3 casts straight in
    typedef enum logic [3:0] {
        alu_add = 4'd0, alu_sll = 4'd1, alu_slt = 4'd2, alu_sltu = 4'd3,
        alu_xor = 4'd4, alu_srl = 4'd5, alu_or = 4'd6, alu_and = 4'd7,
        alu_sub = 4'd8, alu_sra = 4'd9
    } alu_ops;

    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;                   // also b-type imm[12|10:5]
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;                   // also b-type imm[4:1|11]
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;                   // also j-type immediate bits
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } rv32i_instr_u;

endpackage

/* tb_mem_model.sv */
`timescale 1ns/100ps

module tb_mem_model #(
    parameter int seed = 73,
    parameter int max_extra = 3                                   // extra response cycles
) (
    input  logic clk,
    input  logic reset,
    input  logic read,
    input  logic write,
    input  logic [3:0] byte_enable,
    input  logic [31:0] address,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output logic resp,
    output logic wr_seen,                                         // first write since reset
    output logic [31:0] wr_addr,
    output logic [31:0] wr_data,
    output logic [3:0] wr_mask
);

    logic [31:0] mem [1024];                                      // 4 KiB held as words
    logic busy;
    logic in_reset;
    int unsigned wait_left;

    task automatic clear_memory();
        for (int i = 0; i < 1024; i++)
            mem[i] = 32'h5e00_0000 | (i << 2);                    // tagged with its byte address
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[11:2]] = data;
    endtask

    initial
    begin
        void'($urandom(seed));                                    // one seed for the whole run
        resp = 1'b0;
        rdata = '0;
        busy = 1'b0;
        in_reset = 1'b0;
        wait_left = 0;
        wr_seen = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        wr_mask = '0;
        clear_memory();
        forever
        begin
            @(posedge clk);
            in_reset = reset;                                     // reset as the dut saw it here
            #0.5;                                                 // dut outputs settled
            resp = 1'b0;
            if (in_reset)
            begin
                busy = 1'b0;
                wr_seen = 1'b0;
            end
            else if (read || write)
            begin
                if (!busy)
                begin
                    busy = 1'b1;                                  // new request picks its latency
                    wait_left = $urandom % (max_extra + 1);
                end
                if (wait_left == 0)
                begin
                    resp = 1'b1;
                    busy = 1'b0;
                    rdata = mem[address[11:2]];
                    if (write)
                    begin
                        for (int b = 0; b < 4; b++)
                            if (byte_enable[b])
                                mem[address[11:2]][8*b +: 8] = wdata[8*b +: 8];
                        if (!wr_seen)
                        begin
                            wr_seen = 1'b1;                       // keep the first write only
                            wr_addr = address;
                            wr_data = wdata;
                            wr_mask = byte_enable;
                        end
                    end
                end
                else
                    wait_left--;
            end
        end
    end

endmodule

/* tb_mp_cpu.sv */
`timescale 1ns/100ps

module tb_mp_cpu;

    localparam logic [31:0] reset_pc = 32'h0000_0080;
    localparam logic [31:0] report_addr = 32'h0000_0100;         // every program stores x3 here
    localparam logic [31:0] load_addr = 32'h0000_0200;
    localparam logic [31:0] load_value = 32'h5a3c_96e1;
    localparam int timeout_cycles = 500;

    typedef struct {
        string name;
        int a;                                                    // loaded into x1
        int b;                                                    // loaded into x2
        logic [31:0] instr;                                       // instruction under test
        bit skip;                                                 // addi x3, x0, 1 follows it
        logic [31:0] expected;
        logic [3:0] mask;
    } row_t;

    logic clk = 1'b0;
    logic reset;
    logic mem_resp;
    logic [31:0] mem_rdata;
    logic mem_read;
    logic mem_write;
    logic [3:0] mem_byte_enable;
    logic [31:0] mem_address;
    logic [31:0] mem_wdata;
    logic wr_seen;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0] wr_mask;
    row_t rows[$];
    int passed = 0;
    int failed = 0;

    always #2 clk = ~clk;                                         // 4 ns period

    mp_cpu #(.reset_pc(reset_pc)) u_dut (
        .clk             (clk),
        .reset           (reset),
        .mem_resp        (mem_resp),
        .mem_rdata       (mem_rdata),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable),
        .mem_address     (mem_address),
        .mem_wdata       (mem_wdata)
    );

    tb_mem_model #(.seed(73), .max_extra(3)) u_mem (
        .clk         (clk),
        .reset       (reset),
        .read        (mem_read),
        .write       (mem_write),
        .byte_enable (mem_byte_enable),
        .address     (mem_address),
        .wdata       (mem_wdata),
        .rdata       (mem_rdata),
        .resp        (mem_resp),
        .wr_seen     (wr_seen),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_mask     (wr_mask)
    );

    // instruction encoders with rd x3 rs1 x1 rs2 x2 fixed in the r form
    function automatic logic [31:0] r_instr(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_instr(input logic [31:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_instr(input logic [31:0] imm, input logic [4:0] rs2,
                                            input logic [2:0] f3);
        return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};      // base x0
    endfunction

    function automatic logic [31:0] b_instr(input logic [31:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_instr(input logic [19:0] imm20, input logic [6:0] op);
        return {imm20, 5'd3, op};
    endfunction

    function automatic logic [31:0] j_instr(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic add_row(input string name, input int a, input int b, input logic [31:0] instr,
                           input bit skip, input logic [31:0] expected, input logic [3:0] mask);
        row_t r;
        r.name = name;
        r.a = a;
        r.b = b;
        r.instr = instr;
        r.skip = skip;
        r.expected = expected;
        r.mask = mask;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row("add", 5, 7, r_instr(7'h00, 3'b000), 0, 32'd12, 4'b1111);
        add_row("sub", 5, 7, r_instr(7'h20, 3'b000), 0, 32'hffff_fffe, 4'b1111);
        add_row("sll", 3, 4, r_instr(7'h00, 3'b001), 0, 32'd48, 4'b1111);
        add_row("xor", 'h0f0, 'h0ff, r_instr(7'h00, 3'b100), 0, 32'h0000_000f, 4'b1111);
        add_row("or", 'h0f0, 'h00f, r_instr(7'h00, 3'b110), 0, 32'h0000_00ff, 4'b1111);
        add_row("and", 'h0f0, 'h03c, r_instr(7'h00, 3'b111), 0, 32'h0000_0030, 4'b1111);
        add_row("sra", -16, 2, r_instr(7'h20, 3'b101), 0, 32'hffff_fffc, 4'b1111);
        add_row("srl", -16, 28, r_instr(7'h00, 3'b101), 0, 32'h0000_000f, 4'b1111);
        add_row("srai", -256, 0, i_instr(32'h404, 1, 3'b101, 3, 7'b0010011), 0,
                32'hffff_fff0, 4'b1111);
        add_row("addi", -50, 0, i_instr(100, 1, 3'b000, 3, 7'b0010011), 0, 32'd50, 4'b1111);
        add_row("slt", -1, 1, r_instr(7'h00, 3'b010), 0, 32'd1, 4'b1111);      // signed -1 < 1
        add_row("sltu", -1, 1, r_instr(7'h00, 3'b011), 0, 32'd0, 4'b1111);
        add_row("slti", -7, 0, i_instr(-5, 1, 3'b010, 3, 7'b0010011), 0, 32'd1, 4'b1111);
        add_row("lui", 0, 0, u_instr(20'h12345, 7'b0110111), 0, 32'h1234_5000, 4'b1111);
        add_row("auipc", 0, 0, u_instr(20'h00001, 7'b0010111), 0,
                reset_pc + 32'd8 + 32'h1000, 4'b1111);                     // pc of auipc + imm
        add_row("beq", 3, 3, b_instr(8, 3'b000), 1, 32'd0, 4'b1111);       // taken skips addi
        add_row("bne", 3, 3, b_instr(8, 3'b001), 1, 32'd1, 4'b1111);
        add_row("blt", -1, 1, b_instr(8, 3'b100), 1, 32'd0, 4'b1111);
        add_row("bge", -1, 1, b_instr(8, 3'b101), 1, 32'd1, 4'b1111);
        add_row("bltu", -1, 1, b_instr(8, 3'b110), 1, 32'd1, 4'b1111);
        add_row("bgeu", -1, 1, b_instr(8, 3'b111), 1, 32'd0, 4'b1111);
        add_row("jal", 0, 0, j_instr(8, 3), 1, reset_pc + 32'd12, 4'b1111);   // link = pc + 4
        add_row("jalr", int'(reset_pc), 0, i_instr(16, 1, 3'b000, 3, 7'b1100111), 1,
                reset_pc + 32'd12, 4'b1111);                               // target is the store
        add_row("lw", 0, 0, i_instr(load_addr, 0, 3'b010, 3, 7'b0000011), 0,
                load_value, 4'b1111);
        add_row("sb", 'h123, 'h400, r_instr(7'h00, 3'b000), 0, 32'h0000_0523, 4'b0001);
        add_row("sh", -1, 'h0f0, r_instr(7'h00, 3'b100), 0, 32'hffff_ff0f, 4'b0011);
    endtask

    // x1, x2, instruction, optional addi x3, store of x3, self loop
    task automatic load_program(input row_t r);
        logic [31:0] pc;
        logic [2:0] store_f3;
        pc = reset_pc;
        store_f3 = (r.mask == 4'b0001) ? 3'b000 : (r.mask == 4'b0011) ? 3'b001 : 3'b010;
        u_mem.clear_memory();
        u_mem.load_word(load_addr, load_value);
        u_mem.load_word(pc, i_instr(r.a, 0, 3'b000, 1, 7'b0010011));
        pc += 4;
        u_mem.load_word(pc, i_instr(r.b, 0, 3'b000, 2, 7'b0010011));
        pc += 4;
        u_mem.load_word(pc, r.instr);
        pc += 4;
        if (r.skip)
        begin
            u_mem.load_word(pc, i_instr(1, 0, 3'b000, 3, 7'b0010011));
            pc += 4;
        end
        u_mem.load_word(pc, s_instr(report_addr, 3, store_f3));
        pc += 4;
        u_mem.load_word(pc, j_instr(0, 0));                         // jal x0, 0
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #0.5 reset = 1'b1;
        repeat (10) @(posedge clk);
        #0.5 reset = 1'b0;
    endtask

    task automatic run_row(input int idx, input row_t r);
        int cycles;
        bit bad;
        cycles = 0;
        bad = 0;
        fork
            apply_reset();
            begin
                #1 load_program(r);                               // while reset is held
            end
        join
        if (mem_read !== 1'b0)                                    // fetch1 right after reset
        begin
            $display("Mismatch at %0t: mem_read expected 0 got %b", $time, mem_read);
            bad = 1;
        end
        if (mem_write !== 1'b0)
        begin
            $display("Mismatch at %0t: mem_write expected 0 got %b", $time, mem_write);
            bad = 1;
        end
        if (mem_byte_enable !== 4'b1111)
        begin
            $display("Mismatch at %0t: mem_byte_enable expected %b got %b",
                     $time, 4'b1111, mem_byte_enable);
            bad = 1;
        end
        while (!wr_seen && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!wr_seen)
        begin
            $display("test %0d %s: no store reached memory within %0d cycles",
                     idx, r.name, timeout_cycles);
            failed++;
            return;
        end
        if (wr_addr !== report_addr)
        begin
            $display("Mismatch at %0t: mem_address expected %h got %h",
                     $time, report_addr, wr_addr);
            bad = 1;
        end
        if (wr_data !== r.expected)
        begin
            $display("Mismatch at %0t: mem_wdata expected %h got %h",
                     $time, r.expected, wr_data);
            bad = 1;
        end
        if (wr_mask !== r.mask)
        begin
            $display("Mismatch at %0t: mem_byte_enable expected %b got %b",
                     $time, r.mask, wr_mask);
            bad = 1;
        end
        if (bad)
            failed++;
        else
            passed++;
        $display("test %0d %s: %s after %0d cycles",
                 idx, r.name, bad ? "FAILED" : "passed", cycles);
    endtask

    initial
    begin
        reset = 1'b1;                                             // dut held until the first row
        build_table();
        foreach (rows[i])
            run_row(i, rows[i]);
        if (u_dut.u_asserts.fail_count != 0)
            $display("memory protocol assertions failed %0d times", u_dut.u_asserts.fail_count);
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 rows.size(), passed, failed, u_dut.u_asserts.fail_count);
        if (failed == 0 && u_dut.u_asserts.fail_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* tb_mp_cpu_asserts.sv */
`timescale 1ns/100ps

module tb_mp_cpu_asserts (
    input logic clk,
    input logic reset,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic [3:0] mem_byte_enable,
    input logic [31:0] mem_address
);

    int fail_count = 0;                                           // read by the testbench top

    // never a read and a write in the same cycle
    no_read_and_write: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
        else
        begin
            fail_count++;
            $error("mem_read and mem_write high together");
        end

    // request held with a stable address until the response
    request_held: assert property (@(posedge clk) disable iff (reset)
        ((mem_read || mem_write) && !mem_resp) |=>
            ((mem_read || mem_write) && $stable(mem_read) && $stable(mem_address)))
        else
        begin
            fail_count++;
            $error("request dropped or address moved before mem_resp");
        end

    legal_write_mask: assert property (@(posedge clk) disable iff (reset)
        mem_write |-> (mem_byte_enable inside {4'b0001, 4'b0011, 4'b1111}))
        else
        begin
            fail_count++;
            $error("illegal byte enable %b during write", mem_byte_enable);
        end

endmodule

bind mp_cpu tb_mp_cpu_asserts u_asserts (
    .clk             (clk),
    .reset           (reset),
    .mem_read        (mem_read),
    .mem_write       (mem_write),
    .mem_resp        (mem_resp),
    .mem_byte_enable (mem_byte_enable),
    .mem_address     (mem_address)
);
